/* compile.f */
+incdir+hw
hw/audioPkg.sv
hw/audioDma.sv
hw/dualClkFifo.sv
hw/toneIndex.sv
hw/waveTableRom.sv
hw/pwmDuty.sv
hw/audioTx.sv
test/audioTxTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary -j 0 --timescale 1ns/100ps -Wno-fatal
TOP      = audioTxTb
FILELIST = compile.f

OBJDIR   = obj_dir
SIMBIN   = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/audioTxTb.sv */
// Directed testbench for the audio tone player top level
// Models the memory bus, measures PWM duty per period, predicts duties from tone codes
`timescale 1ns/100ps
`include "audio_settings.svh"

module audioTxTb;
	import audioPkg::*;

	localparam int memWords = 1024;

	logic    sysClk = 1'b0;
	logic    audioClk = 1'b0;
	logic    rst;
	dmaCmd_t cmd;
	logic    busy;
	memReq_t memReq;
	memRsp_t memRsp;
	logic    pwm;

	logic [`AUDIO_BUS_WIDTH-1:0] mem [memWords];
	memReq_t                     reqLog [$];
	memReq_t                     prevReq;
	sample_t                     measured [$];
	logic [15:0]                 lfsr;
	int                          ackDelay;
	bit                          ackArmed;
	int                          highCount;
	bit                          metering;
	bit                          sawFull;
	int                          checks = 0;
	int                          errors = 0;

	audioTx DUT (
		.sysClk   (sysClk),
		.audioClk (audioClk),
		.rst      (rst),
		.cmd      (cmd),
		.busy     (busy),
		.memReq   (memReq),
		.memRsp   (memRsp),
		.pwm      (pwm)
	);

	// 4 ns system clock, 6 ns audio clock
	always #2 sysClk = ~sysClk;
	always #3 audioClk = ~audioClk;

	// ----------------------------------------
	// Random source and reference model
	// ----------------------------------------

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | lfsrStep();
		return v;
	endfunction

	// Zero code or note past B
	function automatic bit isRest(input toneCode_t code);
		return (code == '0) || (code.note >= `AUDIO_NOTE_COUNT);
	endfunction

	function automatic phase_t nextPhase(input phase_t phase, input toneCode_t code);
		if (isRest(code))
			return '0;
		return phase + (NOTE_STEP[code.note] << code.octave);
	endfunction

	// 128 + 127 sin(2 pi i / 256) rounded to nearest
	function automatic sample_t sineRef(input sample_t idx);
		real angle;
		angle = 2.0 * 3.14159265358979 * idx / 256.0;
		return sample_t'($rtoi(128.0 + 127.0 * $sin(angle) + 0.5));
	endfunction

	// ----------------------------------------
	// Memory model for the four-phase req/ack bus
	// ----------------------------------------
	always @(posedge sysClk)
	begin
		if (rst)
		begin
			memRsp   <= '0;
			ackArmed = 1'b0;
			prevReq  = '0;
		end
		else
		begin
			if (memReq.req && !prevReq.req && memRsp.ack)
			begin
				errors++;
				$display("Handshake error at %0t: req rose while ack was still high", $time);
			end
			if (memReq.req && prevReq.req && memReq.adrs !== prevReq.adrs)
			begin
				errors++;
				$display("Handshake error at %0t: adrs changed while req was high", $time);
			end
			prevReq = memReq;
			// Phase 4 releases ack 0 to 3 cycles after req drops
			if (memRsp.ack)
			begin
				if (!memReq.req)
				begin
					// Same delay counter as for the ack
					if (!ackArmed)
					begin
						ackDelay = randBits(2);
						ackArmed = 1'b1;
					end
					if (ackDelay == 0)
					begin
						memRsp.ack <= 1'b0;
						ackArmed   = 1'b0;
					end
					else
						ackDelay--;
				end
			end
			else if (memReq.req)
			begin
				// 0 to 3 cycles before ack
				if (!ackArmed)
				begin
					ackDelay = randBits(2);
					ackArmed = 1'b1;
				end
				if (ackDelay == 0)
				begin
					if (memReq.adrs >= memWords)
					begin
						errors++;
						$display("Request at %0t is outside the memory model: %h", $time,
							memReq.adrs);
					end
					memRsp   <= '{ack: 1'b1, data: mem[memReq.adrs[9:0]]};
					ackArmed = 1'b0;
					reqLog.push_back(memReq);
				end
				else
					ackDelay--;
			end
		end
	end

	// Back-pressure seen at the FIFO
	always @(posedge sysClk)
	begin
		if (DUT.fifoFull)
			sawFull = 1'b1;
	end

	// ----------------------------------------
	// PWM duty meter
	// ----------------------------------------

	// pwm sampled here lags the counter by one cycle,
	// so the sample at a period start closes the previous period
	always @(posedge audioClk)
	begin
		if (DUT.audioRst)
		begin
			highCount = 0;
			metering  = 1'b0;
		end
		else if (DUT.periodStart)
		begin
			if (metering)
				measured.push_back(sample_t'(highCount + pwm));
			highCount = 0;
			metering  = 1'b1;
		end
		else
			highCount = highCount + pwm;
	end

	// ----------------------------------------
	// Compares and waits
	// ----------------------------------------
	task automatic compareDuty(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkReq(input string name, input memReq_t got, input memReq_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s: got req %b adrs %h, expected req %b adrs %h", $time, name,
				got.req, got.adrs, exp.req, exp.adrs);
		end
	endtask

	task automatic expectFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Until count duties are measured
	task automatic awaitPeriods(input int count, input int limit, output bit ok);
		int cycles;
		cycles = 0;
		while (measured.size() < count && cycles < limit)
		begin
			@(posedge sysClk);
			cycles++;
		end
		ok = (measured.size() >= count);
		if (!ok)
		begin
			errors++;
			$display("Timeout at %0t: only %0d of %0d PWM periods measured", $time,
				measured.size(), count);
		end
	endtask

	task automatic waitIdle(input int limit, output bit ok);
		int cycles;
		cycles = 0;
		while (busy && cycles < limit)
		begin
			@(posedge sysClk);
			cycles++;
		end
		ok = !busy;
		if (!ok)
		begin
			errors++;
			$display("Timeout at %0t: DMA still busy", $time);
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------

	// Start a list right after a period start and check addresses and duties
	task automatic playList(input string name, input logic [`AUDIO_ADRS_WIDTH-1:0] adrs,
		input int words, input int tail);
		toneCode_t codes [$];
		memReq_t   expReq;
		phase_t    phase;
		sample_t   expDuty;
		int        start;
		int        limit;
		bit        ok;
		// Play order puts the low byte first
		for (int i = 0; i < words; i++)
		begin
			codes.push_back(toneCode_t'(mem[adrs + i][7:0]));
			codes.push_back(toneCode_t'(mem[adrs + i][15:8]));
		end
		limit = (2 * words + 6) * 400;
		start = measured.size() + 1;
		awaitPeriods(start, 800, ok);
		if (!ok)
			return;
		reqLog.delete();
		cmd <= '{en: 1'b1, adrs: adrs, len: `AUDIO_ADRS_WIDTH'(words)};
		@(posedge sysClk);
		cmd.en <= 1'b0;
		@(posedge sysClk);
		// First req one cycle after the command
		expectFlag({name, " busy"}, busy, 1'b1);
		expectFlag({name, " memReq.req"}, memReq.req, 1'b1);
		waitIdle(limit, ok);
		if (!ok)
			return;
		if (reqLog.size() != words)
		begin
			errors++;
			$display("%s: %0d words requested instead of %0d", name, reqLog.size(), words);
		end
		for (int i = 0; i < reqLog.size() && i < words; i++)
		begin
			expReq = '{req: 1'b1, adrs: adrs + `AUDIO_ADRS_WIDTH'(i)};
			checkReq({name, " memReq"}, reqLog[i], expReq);
		end
		// Two idle periods and one per code before the tail
		awaitPeriods(start + 2 + codes.size() + tail, limit, ok);
		if (!ok)
			return;
		compareDuty({name, " idle duty"}, measured[start], 8'd128);
		compareDuty({name, " idle duty"}, measured[start + 1], 8'd128);
		phase = '0;
		foreach (codes[j])
		begin
			phase   = nextPhase(phase, codes[j]);
			expDuty = isRest(codes[j]) ? sample_t'(128)
			                           : sineRef(phase[`AUDIO_PHASE_WIDTH-1 -: 8]);
			compareDuty($sformatf("%s duty %0d", name, j), measured[start + 2 + j], expDuty);
		end
		for (int t = 0; t < tail; t++)
			compareDuty({name, " tail duty"}, measured[start + 2 + codes.size() + t], 8'd128);
	endtask

	task automatic resetTest();
		bit ok;
		expectFlag("memReq.req after reset", memReq.req, 1'b0);
		expectFlag("busy after reset", busy, 1'b0);
		awaitPeriods(1, 1000, ok);
		if (!ok)
			return;
		compareDuty("first period duty", measured[0], 8'd128);
	endtask

	// Octaves 0 to 7
	task automatic toneTest();
		mem[12'h040] = 16'h1409;
		mem[12'h041] = 16'h3B27;
		mem[12'h042] = 16'h5062;
		mem[12'h043] = 16'h7A45;
		playList("tone", 19'h00040, 4, 2);
	endtask

	// Note 12, zero code, note 15 and note 14 as rests before fresh notes
	task automatic restTest();
		mem[12'h100] = 16'h2C24;
		mem[12'h101] = 16'h0035;
		mem[12'h102] = 16'h470F;
		mem[12'h103] = 16'h477E;
		playList("rest", 19'h00100, 4, 2);
	endtask

	// 128 LFSR codes into a 16-entry FIFO
	task automatic backPressureTest();
		sawFull = 1'b0;
		playList("back-pressure", 19'h00200, 64, 2);
		if (!sawFull)
		begin
			errors++;
			$display("FIFO never filled during the 64-word list");
		end
	endtask

	task automatic underrunTest();
		int start;
		bit ok;
		start = measured.size();
		awaitPeriods(start + 4, 2000, ok);
		if (!ok)
			return;
		for (int i = 0; i < 4; i++)
			compareDuty("underrun duty", measured[start + i], 8'd128);
		expectFlag("busy after list", busy, 1'b0);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		rst    = 1'b1;
		cmd    = '0;
		memRsp = '0;
		lfsr   = 16'd43436;
		for (int a = 0; a < memWords; a++)
			mem[a] = `AUDIO_BUS_WIDTH'(randBits(`AUDIO_BUS_WIDTH));
		repeat (16) @(posedge sysClk);
		rst <= 1'b0;
		@(posedge sysClk);
		resetTest();
		toneTest();
		restTest();
		backPressureTest();
		underrunTest();
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* hw/audioTx.sv */
// Top of the audio tone player, memory list in, PWM audio out
// DMA in the sysClk domain, tone synthesis in the audioClk domain
`timescale 1ns/100ps

module audioTx (
	input  logic              sysClk,
	input  logic              audioClk,
	input  logic              rst,
	input  audioPkg::dmaCmd_t cmd,
	output logic              busy,
	output audioPkg::memReq_t memReq,
	input  audioPkg::memRsp_t memRsp,
	output logic              pwm
);
	import audioPkg::*;

	logic      fifoWe;
	toneCode_t fifoWd;
	logic      fifoFull;
	logic      audioRst;
	toneCode_t fifoRd;
	logic      fifoEmpty;
	logic      codeValid;
	logic      periodStart;
	sample_t   toneIdx;
	sample_t   sample;

	// ----------------------------------------
	// sysClk domain
	// ----------------------------------------
	audioDma dma (
		.sysClk   (sysClk),
		.rst      (rst),
		.cmd      (cmd),
		.busy     (busy),
		.memReq   (memReq),
		.memRsp   (memRsp),
		.fifoFull (fifoFull),
		.fifoWe   (fifoWe),
		.fifoWd   (fifoWd)
	);

	// Crossing, popped once per PWM period
	dualClkFifo #(
		.payload_t (toneCode_t)
	) toneFifo (
		.sysClk   (sysClk),
		.audioClk (audioClk),
		.rst      (rst),
		.audioRst (audioRst),
		.we       (fifoWe),
		.wd       (fifoWd),
		.full     (fifoFull),
		.re       (periodStart),
		.rd       (fifoRd),
		.empty    (fifoEmpty)
	);

	// ----------------------------------------
	// audioClk domain
	// ----------------------------------------

	// Empty FIFO at a period start plays a rest
	assign codeValid = !fifoEmpty;

	toneIndex tone (
		.audioClk    (audioClk),
		.audioRst    (audioRst),
		.periodStart (periodStart),
		.code        (fifoRd),
		.codeValid   (codeValid),
		.index       (toneIdx)
	);

	waveTableRom rom (
		.audioClk (audioClk),
		.index    (toneIdx),
		.sample   (sample)
	);

	pwmDuty pwmGen (
		.audioClk    (audioClk),
		.audioRst    (audioRst),
		.duty        (sample),
		.periodStart (periodStart),
		.pwm         (pwm)
	);

endmodule

/* hw/pwmDuty.sv */
// 8-bit PWM, one sample per 256-cycle period
// periodStart pulses while the counter sits at zero
`timescale 1ns/100ps
`include "audio_settings.svh"

module pwmDuty (
	input  logic              audioClk,
	input  logic              audioRst,
	input  audioPkg::sample_t duty,
	output logic              periodStart,
	output logic              pwm
);
	import audioPkg::*;

	sample_t count;
	sample_t dutyHeld;
	sample_t dutyNow;

	assign periodStart = (count == '0);
	// New duty takes effect from the first cycle of its period
	assign dutyNow     = periodStart ? duty : dutyHeld;

	// ----------------------------------------
	// Counter and output
	// ----------------------------------------
	always_ff @(posedge audioClk)
	begin
		if (audioRst)
		begin
			count    <= '0;
			// Mid-scale, the sample for index zero
			dutyHeld <= sample_t'(1 << (`AUDIO_SAMPLE_WIDTH - 1));
			pwm      <= 1'b0;
		end
		else
		begin
			count <= count + 1'b1;
			if (periodStart)
				dutyHeld <= duty;
			// High for exactly dutyNow cycles per period
			pwm <= (count < dutyNow);
		end
	end

endmodule

/* hw/waveTableRom.sv */
// One full sine cycle, 256 entries centred on 128
// Registered read, sample valid one audioClk after index
`timescale 1ns/100ps
`include "audio_settings.svh"

module waveTableRom (
	input  logic              audioClk,
	input  audioPkg::sample_t index,
	output audioPkg::sample_t sample
);
	import audioPkg::*;

	localparam int  entries = 2 ** `AUDIO_SAMPLE_WIDTH;
	localparam real pi      = 3.14159265358979;
	// Midpoint and swing, 128 +/- 127
	localparam real mid     = 2.0 ** (`AUDIO_SAMPLE_WIDTH - 1);
	localparam real swing   = mid - 1.0;

	typedef sample_t table_t [entries];

	// Filled at elaboration, rounded to nearest
	function automatic table_t buildTable();
		table_t t;
		real    angle;
		for (int i = 0; i < entries; i++)
		begin
			angle = 2.0 * pi * i / entries;
			// Always positive, so +0.5 and truncate rounds
			t[i] = sample_t'($rtoi(mid + swing * $sin(angle) + 0.5));
		end
		return t;
	endfunction

	localparam table_t sineTable = buildTable();

	// ----------------------------------------
	// Read port
	// ----------------------------------------
	always_ff @(posedge audioClk)
		sample <= sineTable[index];

endmodule

/* hw/toneIndex.sv */
// Phase accumulator, one step per PWM period
// Turns each tone code into the next sine table index
`timescale 1ns/100ps
`include "audio_settings.svh"

module toneIndex (
	input  logic                audioClk,
	input  logic                audioRst,
	input  logic                periodStart,
	input  audioPkg::toneCode_t code,
	input  logic                codeValid,
	output audioPkg::sample_t   index
);
	import audioPkg::*;

	phase_t phase;
	phase_t step;
	logic   isNote;

	// ----------------------------------------
	// Step lookup
	// ----------------------------------------
	always_comb
	begin
		// Underrun, zero code and notes past B all count as rest
		isNote = codeValid && (code != '0) && (code.note < `AUDIO_NOTE_COUNT);
		step   = '0;
		// Octave shift doubles the frequency, wraps mod 2^24
		if (isNote)
			step = NOTE_STEP[code.note] << code.octave;
	end

	// ----------------------------------------
	// Accumulator
	// ----------------------------------------
	always_ff @(posedge audioClk)
	begin
		if (audioRst)
			phase <= '0;
		else if (periodStart)
		begin
			if (isNote)
				phase <= phase + step;
			else
				// Rest restarts the wave at index zero
				phase <= '0;
		end
	end

	// Top bits select the ROM entry
	assign index = phase[`AUDIO_PHASE_WIDTH-1 -: `AUDIO_SAMPLE_WIDTH];

endmodule

/* hw/dualClkFifo.sv */
// Asynchronous FIFO, writes on sysClk and reads on audioClk
// Read data falls through, also hands out the audio-domain reset
`timescale 1ns/100ps
`include "audio_settings.svh"

module dualClkFifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     sysClk,
	input  logic     audioClk,
	input  logic     rst,
	output logic     audioRst,
	input  logic     we,
	input  payload_t wd,
	output logic     full,
	input  logic     re,
	output payload_t rd,
	output logic     empty
);
	localparam int depth    = `AUDIO_FIFO_DEPTH;
	localparam int adrsBits = $clog2(depth);

	// Pointers carry one extra wrap bit
	typedef logic [adrsBits:0] ptr_t;

	payload_t   mem [depth];
	ptr_t       wrBin;
	ptr_t       wrGray;
	ptr_t       rdBin;
	ptr_t       rdGray;
	ptr_t       wrGraySync1;
	ptr_t       wrGraySync2;
	ptr_t       rdGraySync1;
	ptr_t       rdGraySync2;
	ptr_t       wrBinNext;
	ptr_t       rdBinNext;
	logic [1:0] rstSync;
	logic       doWrite;
	logic       doRead;

	function automatic ptr_t toGray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// ----------------------------------------
	// Audio-domain reset, two flops
	// ----------------------------------------
	always_ff @(posedge audioClk)
		rstSync <= {rstSync[0], rst};

	assign audioRst = rstSync[1];

	// ----------------------------------------
	// Write side, sysClk
	// ----------------------------------------
	assign doWrite   = we && !full;
	assign wrBinNext = wrBin + 1'b1;

	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			wrBin       <= '0;
			wrGray      <= '0;
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
			if (doWrite)
			begin
				wrBin  <= wrBinNext;
				wrGray <= toGray(wrBinNext);
			end
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (doWrite)
			mem[wrBin[adrsBits-1:0]] <= wd;
	end

	// Full when read pointer trails by one lap, top two gray bits flipped
	assign full = (wrGray == {~rdGraySync2[adrsBits -: 2], rdGraySync2[adrsBits-2:0]});

	// ----------------------------------------
	// Read side, audioClk
	// ----------------------------------------
	assign doRead    = re && !empty;
	assign rdBinNext = rdBin + 1'b1;

	always_ff @(posedge audioClk)
	begin
		if (audioRst)
		begin
			rdBin       <= '0;
			rdGray      <= '0;
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end
		else
		begin
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
			if (doRead)
			begin
				rdBin  <= rdBinNext;
				rdGray <= toGray(rdBinNext);
			end
		end
	end

	// Head entry, stable once its write pointer has crossed over
	assign rd    = mem[rdBin[adrsBits-1:0]];
	assign empty = (rdGray == wrGraySync2);

endmodule

/* hw/audioDma.sv */
// Read-only DMA for the tone player, walks a list of words in memory
// Splits each word into two tone codes and pushes them to the FIFO
`timescale 1ns/100ps
`include "audio_settings.svh"

module audioDma (
	input  logic                sysClk,
	input  logic                rst,
	input  audioPkg::dmaCmd_t   cmd,
	output logic                busy,
	output audioPkg::memReq_t   memReq,
	input  audioPkg::memRsp_t   memRsp,
	input  logic                fifoFull,
	output logic                fifoWe,
	output audioPkg::toneCode_t fifoWd
);
	import audioPkg::*;

	localparam int codeBits = $bits(toneCode_t);

	typedef enum logic [2:0] {
		stIdle,
		stWait,
		stReq,
		stPushLo,
		stPushHi
	} state_t;

	state_t                       state;
	logic [`AUDIO_ADRS_WIDTH-1:0] adrs;
	logic [`AUDIO_ADRS_WIDTH-1:0] wordsLeft;
	logic [`AUDIO_BUS_WIDTH-1:0]  word;
	logic                         lastWord;

	assign lastWord = (wordsLeft == `AUDIO_ADRS_WIDTH'(1));

	// ----------------------------------------
	// Handshake FSM
	// ----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (rst)
		begin
			state     <= stIdle;
			wordsLeft <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					// Zero-length list does nothing
					if (cmd.en && cmd.len != '0)
					begin
						wordsLeft <= cmd.len;
						// Never raise req over a stale ack
						state     <= memRsp.ack ? stWait : stReq;
					end
				end
				// Phase 4, memory still releasing ack
				stWait:
				begin
					if (!memRsp.ack)
						state <= stReq;
				end
				// Phases 1 and 2, req held until ack
				stReq:
				begin
					if (memRsp.ack)
						state <= stPushLo;
				end
				// Low byte first, wait out a full FIFO
				stPushLo:
				begin
					if (!fifoFull)
						state <= stPushHi;
				end
				stPushHi:
				begin
					if (!fifoFull)
					begin
						wordsLeft <= wordsLeft - 1'b1;
						if (lastWord)
							state <= stIdle;
						else
							state <= memRsp.ack ? stWait : stReq;
					end
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Address walk and captured word
	always_ff @(posedge sysClk)
	begin
		if (state == stIdle && cmd.en)
			adrs <= cmd.adrs;
		else if (state == stPushHi && !fifoFull)
			adrs <= adrs + 1'b1;
		// Phase 3, data taken as req drops
		if (state == stReq && memRsp.ack)
			word <= memRsp.data;
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	assign memReq.req  = (state == stReq);
	assign memReq.adrs = adrs;
	assign busy        = (state != stIdle);

	// One pulse per byte, only with room in the FIFO
	assign fifoWe = (state == stPushLo || state == stPushHi) && !fifoFull;
	assign fifoWd = (state == stPushHi) ? toneCode_t'(word[codeBits +: codeBits])
	                                    : toneCode_t'(word[0 +: codeBits]);

endmodule

/* hw/audioPkg.sv */
// Bus, tone and sample types plus the note step table
// Shared by the tone player RTL and the testbench reference model
`include "audio_settings.svh"

package audioPkg;

	// ----------------------------------------
	// Memory bus, four-phase req/ack
	// ----------------------------------------

	// DMA to memory
	typedef struct packed {
		logic                         req;
		logic [`AUDIO_ADRS_WIDTH-1:0] adrs;
	} memReq_t;

	// Memory to DMA, data valid while ack is high
	typedef struct packed {
		logic                        ack;
		logic [`AUDIO_BUS_WIDTH-1:0] data;
	} memRsp_t;

	// Start command, len counts words
	typedef struct packed {
		logic                         en;
		logic [`AUDIO_ADRS_WIDTH-1:0] adrs;
		logic [`AUDIO_ADRS_WIDTH-1:0] len;
	} dmaCmd_t;

	// ----------------------------------------
	// Tone path
	// ----------------------------------------

	// Note 12..15 or an all-zero code is a rest
	typedef struct packed {
		logic       spare;
		logic [2:0] octave;
		logic [3:0] note;
	} toneCode_t;

	typedef logic [`AUDIO_SAMPLE_WIDTH-1:0] sample_t;
	typedef logic [`AUDIO_PHASE_WIDTH-1:0]  phase_t;

	// Octave zero phase steps per PWM period, C up to B
	// Each higher octave doubles the step
	localparam phase_t NOTE_STEP [`AUDIO_NOTE_COUNT] = '{
		24'h008000, 24'h00879D, 24'h008FAD, 24'h009838,
		24'h00A145, 24'h00AADC, 24'h00B505, 24'h00BFC9,
		24'h00CB30, 24'h00D745, 24'h00E412, 24'h00F1A2
	};

endpackage

/* hw/audio_settings.svh */
// Sizes shared by the audio tone player RTL and its testbench
// Include in any file that needs a bus, FIFO or phase width
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// ----------------------------------------
// External memory bus
// ----------------------------------------

// Word address width
`define AUDIO_ADRS_WIDTH 19
// Data word, two tone codes per word
`define AUDIO_BUS_WIDTH 16

// ----------------------------------------
// Audio path
// ----------------------------------------

// Clock-crossing FIFO depth, power of two, at least 4
`define AUDIO_FIFO_DEPTH 16
// Phase accumulator, top bits index the sine ROM
`define AUDIO_PHASE_WIDTH 24
// Sample, ROM index and PWM counter width
`define AUDIO_SAMPLE_WIDTH 8
// Notes per octave
`define AUDIO_NOTE_COUNT 12

`endif
